// ==== hw/wino_pkg.sv ====
package wino_pkg;

	localparam int ACC_W = 30;
	localparam int OUT_W = 16;
	localparam int FRAC_SHIFT = 8;
	localparam int TILE_IN = 6;
	localparam int TILE_OUT = 4;
	localparam int ADD_LAT = 3;   // adder tree register levels

	localparam int ROW_W = $clog2(TILE_IN);
	localparam int COL_W = $clog2(TILE_OUT);

	// A^T coefficients 2, 4 and 8 are applied as left shifts
	localparam int SH_X2 = 1;
	localparam int SH_X4 = 2;
	localparam int SH_X8 = 3;

	typedef struct packed {
		logic signed [ACC_W-1:0] v0;
		logic signed [ACC_W-1:0] v1;
		logic signed [ACC_W-1:0] v2;
		logic signed [ACC_W-1:0] v3;
		logic signed [ACC_W-1:0] v4;
		logic signed [ACC_W-1:0] v5;
	} in_row_t;

	typedef struct packed {
		logic signed [ACC_W-1:0] v0;
		logic signed [ACC_W-1:0] v1;
		logic signed [ACC_W-1:0] v2;
		logic signed [ACC_W-1:0] v3;
	} at_row_t;

	typedef struct packed {
		logic [OUT_W-1:0] y0;
		logic [OUT_W-1:0] y1;
		logic [OUT_W-1:0] y2;
		logic [OUT_W-1:0] y3;
	} out_col_t;

	typedef enum logic {
		BUF_IDLE,
		BUF_DRAIN
	} buf_state_e;

endpackage

// ==== hw/wino_adder_tree.sv ====
module wino_adder_tree (
	input  logic                     clk,
	input  logic                     i_arst_n,
	input  wino_pkg::in_row_t        i_a,
	output logic signed [wino_pkg::ACC_W-1:0] o_sum
);
	import wino_pkg::*;

	logic signed [ACC_W-1:0] lvl1 [3];
	logic signed [ACC_W-1:0] lvl2 [2];
	logic signed [ACC_W-1:0] lvl3;

	always_ff @(posedge clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			lvl1 <= '{default: '0};
			lvl2 <= '{default: '0};
			lvl3 <= '0;
		end else begin
			lvl1[0] <= i_a.v0 + i_a.v1;
			lvl1[1] <= i_a.v2 + i_a.v3;
			lvl1[2] <= i_a.v4 + i_a.v5;
			lvl2[0] <= lvl1[0] + lvl1[1];
			lvl2[1] <= lvl1[2];   // carried along to keep the levels aligned
			lvl3 <= lvl2[0] + lvl2[1];   // wraps at ACC_W
		end
	end

	assign o_sum = lvl3;

endmodule

// ==== hw/wino_transform_stage.sv ====
module wino_transform_stage (
	input  logic              clk,
	input  logic              i_arst_n,
	input  logic              i_valid,
	input  wino_pkg::in_row_t i_row,
	output logic              o_valid,
	output wino_pkg::at_row_t o_row
);
	import wino_pkg::*;

	in_row_t ops [TILE_OUT];
	logic signed [ACC_W-1:0] sums [TILE_OUT];
	logic [ADD_LAT-1:0] vld_sr;

	// one operand set per A^T row
	always_comb begin
		ops[0] = '{v0: i_row.v0, v1: i_row.v1, v2: i_row.v2,
			v3: i_row.v3, v4: i_row.v4, v5: '0};
		ops[1] = '{v0: '0, v1: i_row.v1, v2: -i_row.v2,
			v3: i_row.v3 <<< SH_X2, v4: -(i_row.v4 <<< SH_X2), v5: '0};
		ops[2] = '{v0: '0, v1: i_row.v1, v2: i_row.v2,
			v3: i_row.v3 <<< SH_X4, v4: i_row.v4 <<< SH_X4, v5: '0};
		ops[3] = '{v0: '0, v1: i_row.v1, v2: -i_row.v2,
			v3: i_row.v3 <<< SH_X8, v4: -(i_row.v4 <<< SH_X8), v5: i_row.v5};
	end

	for (genvar t = 0; t < TILE_OUT; t++) begin : g_tree
		wino_adder_tree tree_i (
			.clk      (clk),
			.i_arst_n (i_arst_n),
			.i_a      (ops[t]),
			.o_sum    (sums[t])
		);
	end

	always_ff @(posedge clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			vld_sr <= '0;
		end else begin
			vld_sr <= {vld_sr[ADD_LAT-2:0], i_valid};
		end
	end

	assign o_valid = vld_sr[ADD_LAT-1];
	assign o_row = '{v0: sums[0], v1: sums[1], v2: sums[2], v3: sums[3]};

endmodule

// ==== hw/wino_tile_buffer.sv ====
module wino_tile_buffer (
	input  logic              clk,
	input  logic              i_arst_n,
	input  logic              i_valid,
	input  wino_pkg::at_row_t i_row,
	output logic              o_valid,
	output wino_pkg::in_row_t o_col
);
	import wino_pkg::*;

	buf_state_e state;
	logic [ROW_W-1:0] row_cnt;
	logic [COL_W-1:0] col_idx;
	logic tile_done;

	at_row_t collect [TILE_IN-1];   // rows 0..4 while row 5 goes straight to drain
	at_row_t drain [TILE_IN];

	function automatic logic signed [ACC_W-1:0] lane(at_row_t r, logic [COL_W-1:0] j);
		logic signed [ACC_W-1:0] v;
		case (j)
			2'd0: v = r.v0;
			2'd1: v = r.v1;
			2'd2: v = r.v2;
			default: v = r.v3;
		endcase
		return v;
	endfunction

	assign tile_done = i_valid && (row_cnt == ROW_W'(TILE_IN - 1));

	always_ff @(posedge clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			row_cnt <= '0;
		end else if (i_valid) begin
			if (tile_done) begin
				row_cnt <= '0;
			end else begin
				row_cnt <= row_cnt + 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (i_valid && !tile_done) begin
			collect[row_cnt] <= i_row;
		end
		if (tile_done) begin
			for (int r = 0; r < TILE_IN - 1; r++) begin
				drain[r] <= collect[r];
			end
			drain[TILE_IN-1] <= i_row;
		end
	end

	// drain sequencer
	always_ff @(posedge clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			state <= BUF_IDLE;
			col_idx <= '0;
		end else if (tile_done) begin
			state <= BUF_DRAIN;
			col_idx <= '0;
		end else if (state == BUF_DRAIN) begin
			if (col_idx == COL_W'(TILE_OUT - 1)) begin
				state <= BUF_IDLE;
				col_idx <= '0;
			end else begin
				col_idx <= col_idx + 1'b1;
			end
		end
	end

	assign o_valid = (state == BUF_DRAIN);

	always_comb begin
		o_col = '{
			v0: lane(drain[0], col_idx),
			v1: lane(drain[1], col_idx),
			v2: lane(drain[2], col_idx),
			v3: lane(drain[3], col_idx),
			v4: lane(drain[4], col_idx),
			v5: lane(drain[5], col_idx)
		};
	end

	// a tile arrives as one unbroken run of rows
	a_no_row_gap: assert property (@(posedge clk) disable iff (!i_arst_n)
		(row_cnt != '0) |-> i_valid);

endmodule

// ==== hw/wino_output_stage.sv ====
module wino_output_stage (
	input  logic               clk,
	input  logic               i_arst_n,
	input  logic               i_valid,
	input  wino_pkg::at_row_t  i_row,
	output logic               o_valid,
	output wino_pkg::out_col_t o_col
);
	import wino_pkg::*;

	function automatic logic [OUT_W-1:0] rect(logic signed [ACC_W-1:0] v);
		logic [OUT_W-1:0] r;
		if (v[ACC_W-1]) begin
			r = '0;   // negative clamps to zero
		end else begin
			r = v[FRAC_SHIFT+OUT_W-1:FRAC_SHIFT];   // upper bits dropped
		end
		return r;
	endfunction

	always_ff @(posedge clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			o_valid <= 1'b0;
		end else begin
			o_valid <= i_valid;
		end
	end

	always_ff @(posedge clk) begin
		o_col <= '{y0: rect(i_row.v0), y1: rect(i_row.v1),
			y2: rect(i_row.v2), y3: rect(i_row.v3)};
	end

	// each tile leaves as one burst of four columns
	a_burst_len: assert property (@(posedge clk) disable iff (!i_arst_n)
		$rose(o_valid) |=> o_valid [*3] ##1 !o_valid);

endmodule

// ==== hw/inverse_winograd.sv ====
module inverse_winograd (
	input  logic               clk,
	input  logic               i_arst_n,
	input  logic               i_valid,
	input  wino_pkg::in_row_t  i_row,
	output logic               o_valid,
	output wino_pkg::out_col_t o_col
);
	import wino_pkg::*;

	logic    fp_valid;
	at_row_t fp_row;
	logic    buf_valid;
	in_row_t buf_col;
	logic    sp_valid;
	at_row_t sp_row;

	wino_transform_stage fp_i (   // rows times A
		.clk      (clk),
		.i_arst_n (i_arst_n),
		.i_valid  (i_valid),
		.i_row    (i_row),
		.o_valid  (fp_valid),
		.o_row    (fp_row)
	);

	wino_tile_buffer buf_i (
		.clk      (clk),
		.i_arst_n (i_arst_n),
		.i_valid  (fp_valid),
		.i_row    (fp_row),
		.o_valid  (buf_valid),
		.o_col    (buf_col)
	);

	wino_transform_stage sp_i (   // A^T times columns
		.clk      (clk),
		.i_arst_n (i_arst_n),
		.i_valid  (buf_valid),
		.i_row    (buf_col),
		.o_valid  (sp_valid),
		.o_row    (sp_row)
	);

	wino_output_stage out_i (
		.clk      (clk),
		.i_arst_n (i_arst_n),
		.i_valid  (sp_valid),
		.i_row    (sp_row),
		.o_valid  (o_valid),
		.o_col    (o_col)
	);

endmodule

// ==== tb/tb_inverse_winograd.sv ====
module tb_inverse_winograd;
	import wino_pkg::*;

	localparam int TIMEOUT = 100;   // cycles allowed per wait

	logic clk;
	logic i_arst_n;
	logic i_valid;
	in_row_t i_row;
	logic o_valid;
	out_col_t o_col;

	logic [31:0] lfsr_state;
	int tile_m [3][TILE_IN][TILE_IN];   // up to three tiles of M
	int errors;
	int checks;
	int tests_run;
	int tests_bad;

	inverse_winograd dut_i (
		.clk      (clk),
		.i_arst_n (i_arst_n),
		.i_valid  (i_valid),
		.i_row    (i_row),
		.o_valid  (o_valid),
		.o_col    (o_col)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// fibonacci LFSR with taps 32 22 2 1
	function automatic logic next_bit();
		logic fb;
		fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
		lfsr_state = {lfsr_state[30:0], fb};
		return fb;
	endfunction

	function automatic logic [31:0] rand_bits(int n);
		logic [31:0] v;
		v = '0;
		for (int b = 0; b < n; b++) begin
			v = {v[30:0], next_bit()};
		end
		return v;
	endfunction

	function automatic int coef(int t, int k);
		int tbl [4][6];
		tbl = '{'{1, 1, 1, 1, 1, 0}, '{0, 1, -1, 2, -2, 0},
			'{0, 1, 1, 4, 4, 0}, '{0, 1, -1, 8, -8, 1}};
		return tbl[t][k];
	endfunction

	// Y[t][j] of A^T*M*A wrapped to the accumulator width
	function automatic logic signed [ACC_W-1:0] raw_value(int idx, int t, int j);
		longint acc;
		acc = 0;
		for (int k = 0; k < TILE_IN; k++) begin
			for (int c = 0; c < TILE_IN; c++) begin
				acc += longint'(coef(t, k)) * longint'(tile_m[idx][k][c])
					* longint'(coef(j, c));
			end
		end
		return acc[ACC_W-1:0];
	endfunction

	function automatic logic [OUT_W-1:0] expected_value(int idx, int t, int j);
		logic signed [ACC_W-1:0] r;
		r = raw_value(idx, t, j);
		if (r < 0) begin
			return '0;
		end
		return r[23:8];   // shift of 8 and 16 bits kept
	endfunction

	function automatic logic [OUT_W-1:0] lane_of(out_col_t c, int t);
		case (t)
			0: return c.y0;
			1: return c.y1;
			2: return c.y2;
			default: return c.y3;
		endcase
	endfunction

	task automatic drive_tile(int idx);
		for (int k = 0; k < TILE_IN; k++) begin
			@(negedge clk);
			i_valid = 1'b1;
			i_row = '{v0: ACC_W'(tile_m[idx][k][0]), v1: ACC_W'(tile_m[idx][k][1]),
				v2: ACC_W'(tile_m[idx][k][2]), v3: ACC_W'(tile_m[idx][k][3]),
				v4: ACC_W'(tile_m[idx][k][4]), v5: ACC_W'(tile_m[idx][k][5])};
		end
	endtask

	task automatic drive_idle();
		@(negedge clk);
		i_valid = 1'b0;
		i_row = '0;
	endtask

	task automatic fill_tile(int idx, bit rnd);
		int v;
		for (int k = 0; k < TILE_IN; k++) begin
			for (int c = 0; c < TILE_IN; c++) begin
				v = 0;
				if (rnd) begin
					v = rand_bits(20);
					if (v[19]) begin
						v = v - (1 << 20);   // sign extend
					end
				end
				tile_m[idx][k][c] = v;
			end
		end
	endtask

	// counts negedges until o_valid or returns -1 on timeout
	task automatic wait_valid(int start, output int cycles);
		cycles = start;
		while (o_valid !== 1'b1) begin
			if (cycles >= TIMEOUT) begin
				errors++;
				$display("timeout while waiting for o_valid");
				cycles = -1;
				break;
			end
			@(negedge clk);
			cycles++;
		end
	endtask

	task automatic check_burst(int idx);
		logic [OUT_W-1:0] got;
		logic [OUT_W-1:0] exp_v;
		for (int j = 0; j < TILE_OUT; j++) begin
			if (j > 0) begin
				@(negedge clk);
			end
			checks++;
			if (o_valid !== 1'b1) begin
				errors++;
				$display("mismatch tile %0d col %0d o_valid: got %h expected %h",
					idx, j, o_valid, 1'b1);
			end
			for (int t = 0; t < TILE_OUT; t++) begin
				got = lane_of(o_col, t);
				exp_v = expected_value(idx, t, j);
				checks++;
				if (got !== exp_v) begin
					errors++;
					$display("mismatch tile %0d col %0d o_col.y%0d: got %h expected %h",
						idx, j, t, got, exp_v);
				end
			end
		end
		@(negedge clk);
		checks++;
		if (o_valid !== 1'b0) begin
			errors++;
			$display("mismatch tile %0d after burst o_valid: got %h expected %h",
				idx, o_valid, 1'b0);
		end
	endtask

	task automatic check_quiet(int n);
		for (int i = 0; i < n; i++) begin
			@(negedge clk);
			checks++;
			if (o_valid !== 1'b0) begin
				errors++;
				$display("mismatch o_valid while idle: got %h expected %h", o_valid, 1'b0);
			end
		end
	endtask

	task automatic finish_test(string name, int err0);
		tests_run++;
		if (errors == err0) begin
			$display("test %s: ok", name);
		end else begin
			tests_bad++;
			$display("test %s: %0d errors", name, errors - err0);
		end
	endtask

	task automatic test_reset_idle();
		int err0;
		err0 = errors;
		i_arst_n = 1'b0;
		check_quiet(8);
		i_arst_n = 1'b1;
		check_quiet(20);
		finish_test("reset idle", err0);
	endtask

	task automatic test_impulse(int r, int c);
		int err0;
		int cycles;
		err0 = errors;
		fill_tile(0, 1'b0);
		tile_m[0][r][c] = 256;
		drive_tile(0);
		drive_idle();
		wait_valid(1, cycles);
		if (cycles >= 0) begin
			checks++;
			if (cycles != 8) begin
				errors++;
				$display("mismatch o_valid latency: got %h expected %h", cycles, 8);
			end
			check_burst(0);
		end
		finish_test($sformatf("impulse r%0d c%0d", r, c), err0);
	endtask

	task automatic test_single(string name, bit rnd);
		int err0;
		int cycles;
		err0 = errors;
		fill_tile(0, rnd);
		if (!rnd) begin
			tile_m[0][0][0] = 'h3000;   // only feeds Y[0][0]
			tile_m[0][2][1] = 'h5000;   // alternating signs
			tile_m[0][4][3] = -'h1234;
			tile_m[0][5][5] = 'h777;
		end
		drive_tile(0);
		drive_idle();
		wait_valid(1, cycles);
		if (cycles >= 0) begin
			check_burst(0);
		end
		finish_test(name, err0);
	endtask

	task automatic test_back_to_back();
		int err0;
		err0 = errors;
		for (int i = 0; i < 3; i++) begin
			fill_tile(i, 1'b1);
		end
		fork
			begin
				for (int i = 0; i < 3; i++) begin
					drive_tile(i);
				end
				drive_idle();
			end
			begin
				int cycles;
				for (int i = 0; i < 3; i++) begin
					wait_valid(0, cycles);
					if (cycles < 0) begin
						break;
					end
					checks++;
					if (i > 0 && cycles != 2) begin   // idle cycles between bursts
						errors++;
						$display("mismatch o_valid burst gap: got %h expected %h", cycles, 2);
					end
					check_burst(i);
				end
			end
		join
		check_quiet(20);
		finish_test("back to back", err0);
	endtask

	initial begin
		i_arst_n = 1'b0;
		i_valid = 1'b0;
		i_row = '0;
		lfsr_state = 32'hcccc_e6ef;
		errors = 0;
		checks = 0;
		tests_run = 0;
		tests_bad = 0;
		test_reset_idle();
		for (int p = 0; p < TILE_IN; p++) begin
			test_impulse(p, p);
		end
		test_impulse(5, 0);
		test_impulse(0, 5);
		test_single("random tile", 1'b1);
		test_single("rectify", 1'b0);
		test_back_to_back();
		$display("tests %0d, failed %0d, checks %0d, errors %0d",
			tests_run, tests_bad, checks, errors);
		if (errors == 0) begin
			$display("All checks passed");
		end else begin
			$display("Checks failed");
		end
		$finish;
	end

endmodule

// ==== vlog.f ====
hw/wino_pkg.sv
hw/wino_adder_tree.sv
hw/wino_transform_stage.sv
hw/wino_tile_buffer.sv
hw/wino_output_stage.sv
hw/inverse_winograd.sv
tb/tb_inverse_winograd.sv

// ==== Makefile ====
# Verilator build and run for the inverse Winograd back end

VERILATOR ?= verilator
TOP       ?= tb_inverse_winograd
FILELIST  ?= vlog.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0
FAIL_MSG  ?= Checks failed
PASS_MSG  ?= All checks passed

SIM := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(SIM) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "simulation reported failure"; exit 1; \
	fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then \
		echo "simulation ended without a result"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
